//--- Bender.yml
package:
  name: lcd_display

sources:
  # RTL in compile order
  - logic/lcd_pkg.sv
  - logic/lcd_timer.sv
  - logic/spi_byte_tx.sv
  - logic/frame_buffer.sv
  - logic/pixel_scan.sv
  - logic/lcd_sequencer.sv
  - logic/lcd_display_top.sv

  # testbench
  - target: simulation
    files:
      - test/tb_lcd_display_top.sv

//--- logic/frame_buffer.sv
/*
 * Frame buffer with 3 bits per pixel.
 * One registered write port and a read port with two cycles of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int DISP_SIZE = 240
) (
    input  wire                 w_clk,
    input  wire                 rst_n_i,
    input  wire lcd_pkg::fb_wr_t    wr_i,
    input  wire lcd_pkg::fb_addr_t  rd_addr_i,
    output lcd_pkg::rgb3_t      rd_rgb_o
);

    localparam int DEPTH = DISP_SIZE * DISP_SIZE;
    localparam int IDX_W = $clog2(DEPTH);

    lcd_pkg::rgb3_t    mem [DEPTH];
    logic              wr_en_q;
    lcd_pkg::fb_addr_t wr_addr_q;
    lcd_pkg::rgb3_t    wr_rgb_q;
    lcd_pkg::fb_addr_t rd_addr_q;

    function automatic logic [IDX_W-1:0] to_idx(lcd_pkg::fb_addr_t a);
        return IDX_W'(int'(a.row) * DISP_SIZE + int'(a.col));
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) mem[i] = '0;  // black screen
    end

    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) wr_en_q <= 1'b0;
        else wr_en_q <= wr_i.en;
    end

    always_ff @(posedge w_clk) begin
        wr_addr_q <= wr_i.addr;
        wr_rgb_q  <= wr_i.rgb;
        if (wr_en_q) mem[to_idx(wr_addr_q)] <= wr_rgb_q;
        rd_addr_q <= rd_addr_i;                // read stage 1
        rd_rgb_o  <= mem[to_idx(rd_addr_q)];   // read stage 2
    end

    wr_in_range : assert property (@(posedge w_clk) disable iff (!rst_n_i)
        wr_i.en |-> (wr_i.addr.row < DISP_SIZE) && (wr_i.addr.col < DISP_SIZE))
        else $error("frame buffer write outside the panel");

endmodule

`default_nettype wire

//--- logic/lcd_display_top.sv
/*
 * ST7789 display path top level.
 * Frame buffer with an external write port, scanned continuously
 * and streamed to the panel over a write-only SPI link.
 */
`timescale 1ns/1ps
`default_nettype none

module lcd_display_top #(
    parameter int DISP_SIZE   = 240,
    parameter int LCD_ROTATE  = 0,
    parameter int RES_LOW_AT  = 100000,
    parameter int RES_HIGH_AT = 200000,
    parameter int INIT_WAIT   = 1000000
) (
    input  wire                 w_clk,
    input  wire                 rst_n_i,
    input  wire lcd_pkg::fb_wr_t fb_wr_i,
    output lcd_pkg::lcd_pins_t  lcd_o
);

    logic               send;
    logic               busy;
    logic               init_go;
    logic               frame_start;
    logic               pix_next;
    logic               pix_hi;
    logic [7:0]         pix_byte;
    lcd_pkg::spi_word_t word;
    lcd_pkg::fb_addr_t  rd_addr;
    lcd_pkg::rgb3_t     rd_rgb;
    logic               sda;
    logic               scl;
    logic               dc;
    logic               res;

    lcd_timer #(
        .RES_LOW_AT  (RES_LOW_AT),
        .RES_HIGH_AT (RES_HIGH_AT),
        .INIT_WAIT   (INIT_WAIT)
    ) i_lcd_timer (
        .w_clk     (w_clk),
        .rst_n_i   (rst_n_i),
        .busy_i    (busy),
        .res_o     (res),
        .init_go_o (init_go)
    );

    lcd_sequencer #(.DISP_SIZE(DISP_SIZE)) i_lcd_sequencer (
        .w_clk         (w_clk),
        .rst_n_i       (rst_n_i),
        .init_go_i     (init_go),
        .busy_i        (busy),
        .pix_byte_i    (pix_byte),
        .send_o        (send),
        .word_o        (word),
        .frame_start_o (frame_start),
        .pix_next_o    (pix_next),
        .pix_hi_o      (pix_hi)
    );

    pixel_scan #(.DISP_SIZE(DISP_SIZE), .LCD_ROTATE(LCD_ROTATE)) i_pixel_scan (
        .w_clk         (w_clk),
        .rst_n_i       (rst_n_i),
        .frame_start_i (frame_start),
        .pix_next_i    (pix_next),
        .pix_hi_i      (pix_hi),
        .rd_addr_o     (rd_addr),
        .rd_rgb_i      (rd_rgb),
        .pix_byte_o    (pix_byte)
    );

    frame_buffer #(.DISP_SIZE(DISP_SIZE)) i_frame_buffer (
        .w_clk     (w_clk),
        .rst_n_i   (rst_n_i),
        .wr_i      (fb_wr_i),
        .rd_addr_i (rd_addr),
        .rd_rgb_o  (rd_rgb)
    );

    spi_byte_tx i_spi_byte_tx (
        .w_clk   (w_clk),
        .rst_n_i (rst_n_i),
        .send_i  (send),
        .word_i  (word),
        .sda_o   (sda),
        .scl_o   (scl),
        .dc_o    (dc),
        .busy_o  (busy)
    );

    assign lcd_o = '{sda: sda, scl: scl, dc: dc, res: res};  // panel pins

endmodule

`default_nettype wire

//--- logic/lcd_pkg.sv
/*
 * ST7789 display path shared definitions.
 * Pixel, coordinate and SPI word types, the panel command codes
 * and the packed structs carried on the top-level ports.
 */
`default_nettype none

package lcd_pkg;

    localparam int COORD_W = 8;

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t row;
        coord_t col;
    } fb_addr_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb3_t;

    typedef struct packed {
        logic       dc;    // 1 data, 0 command
        logic [7:0] data;
    } spi_word_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        rgb3_t    rgb;
    } fb_wr_t;

    typedef struct packed {
        logic sda;
        logic scl;
        logic dc;
        logic res;
    } lcd_pins_t;

    // ====================
    // ST7789 commands
    localparam logic [7:0] CMD_SWRESET    = 8'h01;
    localparam logic [7:0] CMD_SLPOUT     = 8'h11;
    localparam logic [7:0] CMD_COLMOD     = 8'h3A;
    localparam logic [7:0] CMD_MADCTL     = 8'h36;
    localparam logic [7:0] CMD_INVON      = 8'h21;
    localparam logic [7:0] CMD_NORON      = 8'h13;
    localparam logic [7:0] CMD_DISPON     = 8'h29;
    localparam logic [7:0] CMD_CASET      = 8'h2A;
    localparam logic [7:0] CMD_RASET      = 8'h2B;
    localparam logic [7:0] CMD_RAMWR      = 8'h2C;
    localparam logic [7:0] PIX_FMT_565    = 8'h55;  // 16 bit per pixel
    localparam logic [7:0] MADCTL_DEFAULT = 8'h00;

    localparam int INIT_LEN = 9;   // words in init list
    localparam int HDR_LEN  = 11;  // words in window header

endpackage

`default_nettype wire

//--- logic/lcd_sequencer.sv
/*
 * Word sequencer for the ST7789.
 * Sends the init list paced by the timer, then loops forever over
 * the window header and the two-byte pixel stream.
 */
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer #(
    parameter int DISP_SIZE = 240
) (
    input  wire                 w_clk,
    input  wire                 rst_n_i,
    input  wire                 init_go_i,
    input  wire                 busy_i,
    input  wire [7:0]           pix_byte_i,
    output logic                send_o,
    output lcd_pkg::spi_word_t  word_o,
    output logic                frame_start_o,
    output logic                pix_next_o,
    output logic                pix_hi_o
);

    localparam int         NPIX   = DISP_SIZE * DISP_SIZE;
    localparam int         PIX_W  = $clog2(NPIX + 1);
    localparam logic [7:0] LAST_B = 8'(DISP_SIZE - 1);

    typedef enum logic [1:0] {INIT, HEADER, PIXEL_HI, PIXEL_LO} seq_state_t;

    seq_state_t       state;
    logic [3:0]       idx;       // word index in init list or header
    logic [PIX_W-1:0] pix_cnt;
    logic             last_init;
    logic             last_pix;

    function automatic lcd_pkg::spi_word_t cmd_w(logic [7:0] b);
        return '{dc: 1'b0, data: b};
    endfunction

    function automatic lcd_pkg::spi_word_t dat_w(logic [7:0] b);
        return '{dc: 1'b1, data: b};
    endfunction

    assign last_init = (state == INIT) && (idx == 4'(lcd_pkg::INIT_LEN - 1));
    assign last_pix  = (state == PIXEL_LO) && (pix_cnt == PIX_W'(NPIX - 1));

    // ====================
    // state advances on each accepted word
    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= INIT;
            idx     <= '0;
            pix_cnt <= '0;
            send_o  <= 1'b0;
        end else begin
            send_o <= !busy_i && (state != INIT || init_go_i);
            if (send_o) begin
                case (state)
                    INIT: begin
                        idx   <= last_init ? '0 : idx + 1'b1;
                        state <= last_init ? HEADER : INIT;
                    end
                    HEADER: begin
                        if (idx == 4'(lcd_pkg::HDR_LEN - 1)) begin
                            idx   <= '0;
                            state <= PIXEL_HI;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                    PIXEL_HI: state <= PIXEL_LO;
                    PIXEL_LO: begin
                        pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                        state   <= last_pix ? HEADER : PIXEL_HI;  // next frame
                    end
                endcase
            end
        end
    end

    assign frame_start_o = send_o && (last_init || last_pix);
    assign pix_next_o    = send_o && (state == PIXEL_LO);
    assign pix_hi_o      = (state == PIXEL_HI);

    // ====================
    // word tables
    always_comb begin
        word_o = dat_w(pix_byte_i);  // pixel phases
        if (state == INIT) begin
            case (idx)
                4'd0:    word_o = cmd_w(lcd_pkg::CMD_SWRESET);
                4'd1:    word_o = cmd_w(lcd_pkg::CMD_SLPOUT);
                4'd2:    word_o = cmd_w(lcd_pkg::CMD_COLMOD);
                4'd3:    word_o = dat_w(lcd_pkg::PIX_FMT_565);
                4'd4:    word_o = cmd_w(lcd_pkg::CMD_MADCTL);
                4'd5:    word_o = dat_w(lcd_pkg::MADCTL_DEFAULT);
                4'd6:    word_o = cmd_w(lcd_pkg::CMD_INVON);
                4'd7:    word_o = cmd_w(lcd_pkg::CMD_NORON);
                default: word_o = cmd_w(lcd_pkg::CMD_DISPON);
            endcase
        end else if (state == HEADER) begin
            case (idx)
                4'd0:    word_o = cmd_w(lcd_pkg::CMD_CASET);
                4'd4:    word_o = dat_w(LAST_B);  // last column
                4'd5:    word_o = cmd_w(lcd_pkg::CMD_RASET);
                4'd9:    word_o = dat_w(LAST_B);  // last row
                4'd10:   word_o = cmd_w(lcd_pkg::CMD_RAMWR);
                default: word_o = dat_w(8'h00);
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/lcd_timer.sv
/*
 * Panel power-up timing.
 * A saturating counter from reset release drives the panel reset pulse,
 * and an idle counter on the SPI busy level paces the init commands.
 */
`timescale 1ns/1ps
`default_nettype none

module lcd_timer #(
    parameter int RES_LOW_AT  = 100000,
    parameter int RES_HIGH_AT = 200000,
    parameter int INIT_WAIT   = 1000000
) (
    input  wire  w_clk,
    input  wire  rst_n_i,
    input  wire  busy_i,
    output logic res_o,
    output logic init_go_o
);

    localparam int PWR_W  = $clog2(RES_HIGH_AT + 1);
    localparam int IDLE_W = $clog2(INIT_WAIT + 2);

    logic [PWR_W-1:0]  pwr_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    logic              pwr_done;

    assign pwr_done = (pwr_cnt == PWR_W'(RES_HIGH_AT));

    // ====================
    // power-up counter and reset pulse
    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwr_cnt <= '0;
            res_o   <= 1'b1;
        end else begin
            if (!pwr_done) pwr_cnt <= pwr_cnt + 1'b1;  // saturates
            if (pwr_cnt == PWR_W'(RES_LOW_AT - 1)) begin
                res_o <= 1'b0;  // pulse start
            end else if (pwr_cnt == PWR_W'(RES_HIGH_AT - 1)) begin
                res_o <= 1'b1;  // release panel
            end
        end
    end

    // ====================
    // idle gap between words
    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idle_cnt <= '0;
        end else if (busy_i) begin
            idle_cnt <= '0;
        end else if (idle_cnt != IDLE_W'(INIT_WAIT + 1)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign init_go_o = pwr_done && (idle_cnt > IDLE_W'(INIT_WAIT));

    // the pulse happens once per reset
    res_stays_high : assert property (@(posedge w_clk) disable iff (!rst_n_i)
        (pwr_done && res_o) |=> res_o)
        else $error("panel reset fell after power-up");

endmodule

`default_nettype wire

//--- logic/pixel_scan.sv
/*
 * Raster scanner for the pixel stream.
 * Walks x/y over the panel, maps them through the selected rotation
 * to a buffer address, and expands the fetched color to RGB565.
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_scan #(
    parameter int DISP_SIZE  = 240,
    parameter int LCD_ROTATE = 0
) (
    input  wire                     w_clk,
    input  wire                     rst_n_i,
    input  wire                     frame_start_i,
    input  wire                     pix_next_i,
    input  wire                     pix_hi_i,
    output lcd_pkg::fb_addr_t       rd_addr_o,
    input  wire lcd_pkg::rgb3_t     rd_rgb_i,
    output logic [7:0]              pix_byte_o
);

    localparam lcd_pkg::coord_t LAST = lcd_pkg::coord_t'(DISP_SIZE - 1);

    lcd_pkg::coord_t x_q;
    lcd_pkg::coord_t y_q;
    lcd_pkg::rgb3_t  color_q;
    logic [15:0]     rgb565;

    // ====================
    // raster counters
    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (frame_start_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (pix_next_i) begin
            if (x_q == LAST) begin
                x_q <= '0;
                y_q <= (y_q == LAST) ? '0 : y_q + 1'b1;
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    // rotation to buffer row/column
    always_comb begin
        case (LCD_ROTATE)
            1:       rd_addr_o = '{row: x_q, col: LAST - y_q};         // 90 deg
            2:       rd_addr_o = '{row: LAST - y_q, col: LAST - x_q};  // 180 deg
            3:       rd_addr_o = '{row: LAST - x_q, col: y_q};         // 270 deg
            default: rd_addr_o = '{row: y_q, col: x_q};
        endcase
    end

    always_ff @(posedge w_clk) begin
        color_q <= rd_rgb_i;
    end

    assign rgb565     = {{5{color_q.r}}, {6{color_q.g}}, {5{color_q.b}}};
    assign pix_byte_o = pix_hi_i ? rgb565[15:8] : rgb565[7:0];  // high byte goes first

endmodule

`default_nettype wire

//--- logic/spi_byte_tx.sv
/*
 * Write-only SPI serializer for the ST7789.
 * Shifts one DC flag plus byte out MSB first, SCL idles high,
 * four clock cycles per bit, data sampled on the rising SCL.
 */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_tx (
    input  wire                 w_clk,
    input  wire                 rst_n_i,
    input  wire                 send_i,
    input  wire lcd_pkg::spi_word_t word_i,
    output logic                sda_o,
    output logic                scl_o,
    output logic                dc_o,
    output logic                busy_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PRESENT,
        S_FALL,
        S_HOLD,
        S_RISE
    } tx_state_t;

    tx_state_t  state;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;

    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
            sda_o   <= 1'b0;
            scl_o   <= 1'b1;
            dc_o    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (send_i) begin
                        dc_o    <= word_i.dc;
                        bit_cnt <= '0;
                        state   <= S_PRESENT;
                    end
                end
                S_PRESENT: begin
                    sda_o <= shreg[7];  // changes while scl high
                    state <= S_FALL;
                end
                S_FALL: begin
                    scl_o <= 1'b0;
                    state <= S_HOLD;
                end
                S_HOLD:  state <= S_RISE;
                S_RISE: begin
                    scl_o   <= 1'b1;  // panel samples here
                    bit_cnt <= bit_cnt + 1'b1;
                    state   <= (bit_cnt == 3'd7) ? S_IDLE : S_PRESENT;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge w_clk) begin
        if (send_i && state == S_IDLE) shreg <= word_i.data;
        else if (state == S_PRESENT) shreg <= {shreg[6:0], 1'b0};
    end

    assign busy_o = send_i || (state != S_IDLE);

    no_send_in_flight : assert property (@(posedge w_clk) disable iff (!rst_n_i)
        send_i |-> state == S_IDLE)
        else $error("send strobe while a word is shifting");

endmodule

`default_nettype wire

//--- test/lcd_patterns.txt
// entries 0-8: init words, dc flag in bit 8 then the byte
// entry 9: write count, then writes as row(2 hex) col(2 hex) rgb(1 hex)
// rotation under test: 1 (scan x,y reads row x, column 3-y)
001
011
03A
155
036
100
021
013
029
7
00005
00037
01024
02012
03031
03006
01022

//--- test/tb_lcd_display_top.sv
/*
 * Testbench for the ST7789 display top level.
 * Loads init words and pixel writes from the pattern file, decodes the
 * SPI stream back into 9-bit words and checks reset timing, the init
 * list, the window header and two frames of pixel bytes.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_display_top;

    localparam int DISP_SIZE   = 4;
    localparam int LCD_ROTATE  = 1;
    localparam int RES_LOW_AT  = 20;
    localparam int RES_HIGH_AT = 40;
    localparam int INIT_WAIT   = 30;

    localparam int NPIX        = DISP_SIZE * DISP_SIZE;
    localparam int FRAME_WORDS = lcd_pkg::HDR_LEN + 2 * NPIX;
    localparam int NUM_FRAMES  = 2;
    localparam int TOTAL_WORDS = lcd_pkg::INIT_LEN + NUM_FRAMES * FRAME_WORDS;
    localparam int RUN_LEN     = 40 + 9 * (INIT_WAIT + 40) + 3 * FRAME_WORDS * 40;
    localparam int TIMEOUT     = 2 * RUN_LEN;
    localparam int PAT_DEPTH   = 32;

    localparam logic [0:8] INIT_DC = 9'b000101000;  // dc flag per init word

    logic               w_clk = 1'b0;
    logic               rst_n_i;
    lcd_pkg::fb_wr_t    fb_wr_i;
    lcd_pkg::lcd_pins_t lcd_o;

    logic [19:0] pat [PAT_DEPTH];
    logic [2:0]  shadow [NPIX];   // expected buffer contents
    logic [8:0]  exp_words [$];
    int          n_writes;
    int          n_words = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          cyc = 0;         // edges since reset release
    int          tick = 0;
    int          prev_rise = -1;
    int          prev_fall = -1;
    int          bit_cnt = 0;
    logic        scl_q = 1'b1;
    logic        res_exp;
    logic        dc_s;
    logic [7:0]  shreg;
    logic [8:0]  got;

    lcd_display_top #(
        .DISP_SIZE   (DISP_SIZE),
        .LCD_ROTATE  (LCD_ROTATE),
        .RES_LOW_AT  (RES_LOW_AT),
        .RES_HIGH_AT (RES_HIGH_AT),
        .INIT_WAIT   (INIT_WAIT)
    ) i_lcd_display_top (
        .w_clk   (w_clk),
        .rst_n_i (rst_n_i),
        .fb_wr_i (fb_wr_i),
        .lcd_o   (lcd_o)
    );

    always #20 w_clk = ~w_clk;  // 40 ns period

    function automatic logic [15:0] to_rgb565(logic [2:0] c);
        logic [15:0] v;
        v = 16'h0000;
        if (c[2]) v = v | 16'hF800;  // red field
        if (c[1]) v = v | 16'h07E0;  // green field
        if (c[0]) v = v | 16'h001F;
        return v;
    endfunction

    function automatic string word_name(int n);
        int k;
        if (n < lcd_pkg::INIT_LEN) return "init";
        k = (n - lcd_pkg::INIT_LEN) % FRAME_WORDS;
        if (k < lcd_pkg::HDR_LEN) return "header";
        return "pixel";
    endfunction

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d words checked",
                 mismatch_cnt, other_cnt, n_words, TOTAL_WORDS);
    endtask

    // ====================
    // expected stream from the pattern file
    task automatic build_expected();
        logic [15:0] px;
        int          idx;
        for (int i = 0; i < lcd_pkg::INIT_LEN; i++) begin
            assert (pat[i][8] == INIT_DC[i]) else begin
                mismatch_cnt++;
                $display("Mismatch init_dc word %0d: expected %b, actual %b",
                         i, INIT_DC[i], pat[i][8]);
            end
            exp_words.push_back(pat[i][8:0]);
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            exp_words.push_back({1'b0, lcd_pkg::CMD_CASET});
            exp_words.push_back(9'h100);
            exp_words.push_back(9'h100);
            exp_words.push_back(9'h100);
            exp_words.push_back({1'b1, 8'(DISP_SIZE - 1)});
            exp_words.push_back({1'b0, lcd_pkg::CMD_RASET});
            exp_words.push_back(9'h100);
            exp_words.push_back(9'h100);
            exp_words.push_back(9'h100);
            exp_words.push_back({1'b1, 8'(DISP_SIZE - 1)});
            exp_words.push_back({1'b0, lcd_pkg::CMD_RAMWR});
            for (int y = 0; y < DISP_SIZE; y++) begin
                for (int x = 0; x < DISP_SIZE; x++) begin
                    idx = x * DISP_SIZE + (DISP_SIZE - 1 - y);  // row x, col last-y
                    px  = to_rgb565(shadow[idx]);
                    exp_words.push_back({1'b1, px[15:8]});
                    exp_words.push_back({1'b1, px[7:0]});
                end
            end
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        fb_wr_i = '0;
        $readmemh("test/lcd_patterns.txt", pat);
        n_writes = int'(pat[lcd_pkg::INIT_LEN]);
        assert (!$isunknown(pat[lcd_pkg::INIT_LEN])) else begin
            other_cnt++;
            n_writes = 0;
            $display("pattern file is missing or has no write count");
        end
        for (int i = 0; i < NPIX; i++) shadow[i] = 3'b000;  // black
        for (int i = 0; i < n_writes; i++) begin
            shadow[int'(pat[10+i][19:12]) * DISP_SIZE + int'(pat[10+i][11:4])] =
                pat[10+i][2:0];
        end
        build_expected();

        repeat (5) @(posedge w_clk);
        rst_n_i <= 1'b1;

        // pixel writes land while the init list is still running
        for (int i = 0; i < n_writes; i++) begin
            @(posedge w_clk);
            fb_wr_i.en       <= 1'b1;
            fb_wr_i.addr.row <= pat[10+i][19:12];
            fb_wr_i.addr.col <= pat[10+i][11:4];
            fb_wr_i.rgb      <= pat[10+i][2:0];
        end
        @(posedge w_clk);
        fb_wr_i.en <= 1'b0;

        while (n_words < TOTAL_WORDS) @(posedge w_clk);
        print_counts();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // ====================
    // panel reset check and SPI decoder
    always @(posedge w_clk) begin
        if (rst_n_i) begin
            res_exp = !(cyc >= RES_LOW_AT && cyc < RES_HIGH_AT);
            assert (lcd_o.res == res_exp) else begin
                mismatch_cnt++;
                $display("Mismatch panel_reset cycle %0d: expected %b, actual %b",
                         cyc, res_exp, lcd_o.res);
            end
            if (!lcd_o.scl && scl_q) begin  // falling scl
                if (prev_fall >= 0) assert (cyc - prev_fall >= 4) else begin
                    other_cnt++;
                    $display("SCL fell %0d cycles after the previous fall", cyc - prev_fall);
                end
                if (bit_cnt == 0 && n_words < lcd_pkg::INIT_LEN) begin
                    assert (cyc - (prev_rise < 0 ? 0 : prev_rise) >= INIT_WAIT) else begin
                        other_cnt++;
                        $display("init word %0d started after too short an idle gap",
                                 n_words);
                    end
                    if (n_words == 0) assert (cyc >= RES_HIGH_AT) else begin
                        other_cnt++;
                        $display("first init word started before the panel left reset");
                    end
                end
                prev_fall = cyc;
            end
            if (lcd_o.scl && !scl_q) begin  // rising scl is the sample point
                if (prev_rise >= 0) assert (cyc - prev_rise >= 4) else begin
                    other_cnt++;
                    $display("SCL rose %0d cycles after the previous rise", cyc - prev_rise);
                end
                prev_rise = cyc;
                shreg     = {shreg[6:0], lcd_o.sda};
                dc_s      = lcd_o.dc;
                bit_cnt++;
                if (bit_cnt == 8) begin
                    got     = {dc_s, shreg};
                    bit_cnt = 0;
                    if (n_words < TOTAL_WORDS) begin
                        assert (got == exp_words[n_words]) else begin
                            mismatch_cnt++;
                            $display("Mismatch %s word %0d: expected %03h, actual %03h",
                                     word_name(n_words), n_words, exp_words[n_words], got);
                        end
                        n_words++;
                    end
                end
            end
            scl_q = lcd_o.scl;
            cyc++;
        end
    end

    // run limit
    always @(posedge w_clk) begin
        tick++;
        if (tick >= TIMEOUT) begin
            other_cnt++;
            $display("timeout after %0d cycles waiting for SPI words", tick);
            print_counts();
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/lcd_pkg.sv
logic/lcd_timer.sv
logic/spi_byte_tx.sv
logic/frame_buffer.sv
logic/pixel_scan.sv
logic/lcd_sequencer.sv
logic/lcd_display_top.sv
test/tb_lcd_display_top.sv
